//--- design/branch_alu.sv
`timescale 1ns/1ps

module branch_alu (
    input  logic                        valid_i,
    input  ex_pkg::alu_op_e             op_i,
    input  logic [ex_pkg::XLEN-1:0]     pc_i,
    input  logic [ex_pkg::INST_W-1:0]   inst_i,
    input  logic [ex_pkg::XLEN-1:0]     reg1_i,
    input  logic [ex_pkg::XLEN-1:0]     reg2_i,
    input  logic                        pred_taken_i,
    input  logic [ex_pkg::XLEN-1:0]     pred_addr_i,
    output logic                        update_valid_o,
    output logic                        taken_o,
    output logic [ex_pkg::XLEN-1:0]     target_o,
    output logic                        flush_o,
    output logic [ex_pkg::XLEN-1:0]     link_o
);
    import ex_pkg::*;

    logic            taken;
    logic            eq;
    logic            lt_s;
    logic            lt_u;
    logic [XLEN-1:0] offs16;
    logic [XLEN-1:0] offs26;
    logic [XLEN-1:0] target;
    logic [XLEN-1:0] pc_plus4;

    assign eq       = reg1_i == reg2_i;
    assign lt_s     = $signed(reg1_i) < $signed(reg2_i);
    assign lt_u     = reg1_i < reg2_i;
    assign pc_plus4 = pc_i + 32'd4;
    assign offs16   = {{14{inst_i[25]}}, inst_i[25:10], 2'b00};
    // b/bl keep the upper offset bits in inst[9:0]
    assign offs26   = {{4{inst_i[9]}}, inst_i[9:0], inst_i[25:10], 2'b00};

    always_comb begin
        case (op_i)
            ALU_BEQ:                 taken = eq;
            ALU_BNE:                 taken = !eq;
            ALU_BLT:                 taken = lt_s;
            ALU_BGE:                 taken = !lt_s;
            ALU_BLTU:                taken = lt_u;
            ALU_BGEU:                taken = !lt_u;
            ALU_JIRL, ALU_B, ALU_BL: taken = 1'b1;
            default:                 taken = 1'b0;
        endcase
    end

    assign target = (op_i == ALU_JIRL) ? reg1_i + offs16 :
                    (op_i == ALU_B || op_i == ALU_BL) ? pc_i + offs26 : pc_i + offs16;

    assign update_valid_o = valid_i && (get_op_class(op_i) == CLS_BRANCH);
    assign taken_o        = taken;
    // redirect address for the front end
    assign target_o       = taken ? target : pc_plus4;
    assign flush_o        = update_valid_o && ((taken != pred_taken_i)
                            || (taken && pred_taken_i && (target != pred_addr_i)));
    assign link_o         = (op_i == ALU_BL || op_i == ALU_JIRL) ? pc_plus4 : '0;

endmodule

//--- design/div_alu.sv
`timescale 1ns/1ps

module div_alu (
    input  logic                        clk,
    input  logic                        arst_n_i,
    input  logic                        valid_i,
    input  ex_pkg::alu_op_e             op_i,
    input  logic [ex_pkg::XLEN-1:0]     dividend_i,
    input  logic [ex_pkg::XLEN-1:0]     divisor_i,
    output logic                        stall_o,
    output logic                        done_o,
    output logic [ex_pkg::XLEN-1:0]     quotient_o,
    output logic [ex_pkg::XLEN-1:0]     remainder_o
);
    import ex_pkg::*;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_BUSY,
        DIV_DONE
    } div_state_e;

    div_state_e      state_q;
    logic [4:0]      cnt_q;
    logic            start;
    logic            is_signed;
    logic            a_neg;
    logic            b_neg;
    logic [XLEN-1:0] a_mag;
    logic [XLEN-1:0] b_mag;
    logic [XLEN-1:0] quo_q;
    logic [XLEN-1:0] rem_q;
    logic [XLEN-1:0] divisor_q;
    logic            quo_neg_q;
    logic            rem_neg_q;
    logic [XLEN:0]   trial;
    logic [XLEN:0]   diff;
    logic            fits;

    assign is_signed = (op_i == ALU_DIVW) || (op_i == ALU_MODW);
    assign start     = valid_i && (get_op_class(op_i) == CLS_DIV) && (state_q == DIV_IDLE);
    assign a_neg     = is_signed && dividend_i[XLEN-1];
    assign b_neg     = is_signed && divisor_i[XLEN-1];
    assign a_mag     = a_neg ? -dividend_i : dividend_i;
    assign b_mag     = b_neg ? -divisor_i : divisor_i;

    // next dividend bit comes out of the top of quo_q
    assign trial = {rem_q, quo_q[XLEN-1]};
    assign diff  = trial - {1'b0, divisor_q};
    assign fits  = trial >= {1'b0, divisor_q};

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= DIV_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                DIV_IDLE: begin
                    cnt_q <= '0;
                    if (start) begin
                        state_q <= DIV_BUSY;
                    end
                end
                DIV_BUSY: begin
                    cnt_q <= cnt_q + 5'd1;
                    if (cnt_q == 5'd31) begin
                        state_q <= DIV_DONE;
                    end
                end
                default: state_q <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            quo_q     <= a_mag;
            rem_q     <= '0;
            divisor_q <= b_mag;
            quo_neg_q <= a_neg ^ b_neg;
            rem_neg_q <= a_neg;
        end else if (state_q == DIV_BUSY) begin
            quo_q <= {quo_q[XLEN-2:0], fits};
            rem_q <= fits ? diff[XLEN-1:0] : trial[XLEN-1:0];
        end
    end

    assign stall_o     = start || (state_q == DIV_BUSY);
    assign done_o      = (state_q == DIV_DONE);
    assign quotient_o  = quo_neg_q ? -quo_q : quo_q;
    assign remainder_o = rem_neg_q ? -rem_q : rem_q;

    // done only while the divide is still held in execute
    assert property (@(posedge clk) disable iff (!arst_n_i)
        done_o |-> valid_i && (get_op_class(op_i) == CLS_DIV));

endmodule

//--- design/ex_dispatch_reg.sv
`timescale 1ns/1ps

module ex_dispatch_reg (
    input  logic                        clk,
    input  logic                        arst_n_i,
    input  logic                        disp_valid_i,
    input  ex_pkg::alu_op_e             disp_op_i,
    input  logic [ex_pkg::XLEN-1:0]     disp_pc_i,
    input  logic [ex_pkg::INST_W-1:0]   disp_inst_i,
    input  logic [ex_pkg::XLEN-1:0]     disp_reg1_i,
    input  logic [ex_pkg::XLEN-1:0]     disp_reg2_i,
    input  logic                        disp_pred_taken_i,
    input  logic [ex_pkg::XLEN-1:0]     disp_pred_addr_i,
    input  logic                        stall_i,
    output logic                        ex_valid_o,
    output ex_pkg::alu_op_e             ex_op_o,
    output logic [ex_pkg::XLEN-1:0]     ex_pc_o,
    output logic [ex_pkg::INST_W-1:0]   ex_inst_o,
    output logic [ex_pkg::XLEN-1:0]     ex_reg1_o,
    output logic [ex_pkg::XLEN-1:0]     ex_reg2_o,
    output logic                        ex_pred_taken_o,
    output logic [ex_pkg::XLEN-1:0]     ex_pred_addr_o
);
    import ex_pkg::*;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_valid_o <= 1'b0;
            ex_op_o    <= ALU_NOP;
        end else if (!stall_i) begin
            ex_valid_o <= disp_valid_i;
            // empty slot travels as a nop
            ex_op_o    <= disp_valid_i ? disp_op_i : ALU_NOP;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            ex_pc_o         <= disp_pc_i;
            ex_inst_o       <= disp_inst_i;
            ex_reg1_o       <= disp_reg1_i;
            ex_reg2_o       <= disp_reg2_i;
            ex_pred_taken_o <= disp_pred_taken_i;
            ex_pred_addr_o  <= disp_pred_addr_i;
        end
    end

    // instruction in execute frozen during a stall
    assert property (@(posedge clk) disable iff (!arst_n_i)
        stall_i |=> $stable(ex_valid_o) && $stable(ex_op_o) && $stable(ex_pc_o)
                    && $stable(ex_reg1_o) && $stable(ex_reg2_o) && $stable(ex_inst_o));

endmodule

//--- design/ex_mem_reg.sv
`timescale 1ns/1ps

module ex_mem_reg (
    input  logic                        clk,
    input  logic                        arst_n_i,
    input  logic                        ex_valid_i,
    input  ex_pkg::alu_op_e             ex_op_i,
    input  logic [ex_pkg::XLEN-1:0]     ex_pc_i,
    input  logic [ex_pkg::XLEN-1:0]     alu_res_i,
    input  logic [ex_pkg::XLEN-1:0]     quotient_i,
    input  logic [ex_pkg::XLEN-1:0]     remainder_i,
    input  logic                        div_stall_i,
    input  logic [ex_pkg::XLEN-1:0]     link_i,
    input  logic [ex_pkg::XLEN-1:0]     mem_addr_i,
    input  mem_pkg::exc_cause_e         exc_i,
    input  logic                        mem_stall_i,
    output logic                        stall_o,
    output logic                        mem_valid_o,
    output ex_pkg::alu_op_e             mem_op_o,
    output logic [ex_pkg::XLEN-1:0]     mem_pc_o,
    output logic [ex_pkg::XLEN-1:0]     mem_result_o,
    output logic [ex_pkg::XLEN-1:0]     mem_addr_o,
    output mem_pkg::exc_cause_e         mem_exc_o
);
    import ex_pkg::*;
    import mem_pkg::*;

    logic [XLEN-1:0] result;

    assign stall_o = div_stall_i || mem_stall_i;

    always_comb begin
        case (get_op_class(ex_op_i))
            CLS_REG:    result = alu_res_i;
            CLS_DIV:    result = (ex_op_i == ALU_MODW || ex_op_i == ALU_MODWU) ?
                                 remainder_i : quotient_i;
            CLS_BRANCH: result = link_i;
            // load data is filled in by the memory stage
            default:    result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mem_valid_o <= 1'b0;
            mem_op_o    <= ALU_NOP;
            mem_exc_o   <= EXC_NONE;
        end else begin
            mem_valid_o <= ex_valid_i && !stall_o;
            mem_op_o    <= stall_o ? ALU_NOP : ex_op_i;
            mem_exc_o   <= stall_o ? EXC_NONE : exc_i;
        end
    end

    always_ff @(posedge clk) begin
        mem_pc_o     <= ex_pc_i;
        mem_result_o <= result;
        mem_addr_o   <= mem_addr_i;
    end

    // a stalled instruction leaves a bubble behind
    assert property (@(posedge clk) disable iff (!arst_n_i)
        stall_o |=> !mem_valid_o);

endmodule

//--- design/ex_pkg.sv
package ex_pkg;

    localparam int XLEN   = 32;
    localparam int INST_W = 32;

    typedef enum logic [5:0] {
        ALU_NOP,
        // regular alu
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
        ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLL, ALU_SRL, ALU_SRA,
        // divider
        ALU_DIVW, ALU_MODW, ALU_DIVWU, ALU_MODWU,
        // branch unit
        ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU,
        ALU_JIRL, ALU_B, ALU_BL,
        // load/store
        ALU_LDB, ALU_LDBU, ALU_LDH, ALU_LDHU, ALU_LDW,
        ALU_STB, ALU_STH, ALU_STW
    } alu_op_e;

    typedef enum logic [2:0] {
        CLS_REG,
        CLS_DIV,
        CLS_BRANCH,
        CLS_MEM,
        CLS_NONE
    } op_class_e;

    function automatic op_class_e get_op_class(alu_op_e op);
        case (op)
            ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
            ALU_SLL, ALU_SRL, ALU_SRA: return CLS_REG;
            ALU_DIVW, ALU_MODW, ALU_DIVWU, ALU_MODWU: return CLS_DIV;
            ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU,
            ALU_JIRL, ALU_B, ALU_BL: return CLS_BRANCH;
            ALU_LDB, ALU_LDBU, ALU_LDH, ALU_LDHU, ALU_LDW,
            ALU_STB, ALU_STH, ALU_STW: return CLS_MEM;
            default: return CLS_NONE;
        endcase
    endfunction

endpackage

//--- design/ex_stage_top.sv
`timescale 1ns/1ps

module ex_stage_top (
    input  logic                        clk,
    input  logic                        arst_n_i,
    input  logic                        disp_valid_i,
    input  ex_pkg::alu_op_e             disp_op_i,
    input  logic [ex_pkg::XLEN-1:0]     disp_pc_i,
    input  logic [ex_pkg::INST_W-1:0]   disp_inst_i,
    input  logic [ex_pkg::XLEN-1:0]     disp_reg1_i,
    input  logic [ex_pkg::XLEN-1:0]     disp_reg2_i,
    input  logic                        disp_pred_taken_i,
    input  logic [ex_pkg::XLEN-1:0]     disp_pred_addr_i,
    input  logic                        dcache_addr_ok_i,
    output logic                        dcache_valid_o,
    output mem_pkg::mem_op_e            dcache_op_o,
    output logic [ex_pkg::XLEN-1:0]     dcache_addr_o,
    output logic [ex_pkg::XLEN-1:0]     dcache_wdata_o,
    output logic [mem_pkg::STRB_W-1:0]  dcache_wstrb_o,
    output logic                        branch_flush_o,
    output logic                        bpu_update_valid_o,
    output logic                        bpu_taken_o,
    output logic [ex_pkg::XLEN-1:0]     bpu_target_o,
    output logic                        stall_o,
    output logic                        mem_valid_o,
    output ex_pkg::alu_op_e             mem_op_o,
    output logic [ex_pkg::XLEN-1:0]     mem_pc_o,
    output logic [ex_pkg::XLEN-1:0]     mem_result_o,
    output logic [ex_pkg::XLEN-1:0]     mem_addr_o,
    output mem_pkg::exc_cause_e         mem_exc_o
);
    import ex_pkg::*;
    import mem_pkg::*;

    logic              ex_valid;
    alu_op_e           ex_op;
    logic [XLEN-1:0]   ex_pc;
    logic [INST_W-1:0] ex_inst;
    logic [XLEN-1:0]   ex_reg1;
    logic [XLEN-1:0]   ex_reg2;
    logic              ex_pred_taken;
    logic [XLEN-1:0]   ex_pred_addr;
    logic [XLEN-1:0]   alu_res;
    logic [XLEN-1:0]   quotient;
    logic [XLEN-1:0]   remainder;
    logic              div_stall;
    logic              div_done;
    logic [XLEN-1:0]   link;
    logic [XLEN-1:0]   lsu_addr;
    exc_cause_e        lsu_exc;
    logic              mem_stall;

    ex_dispatch_reg u_ex_dispatch_reg (
        .clk, .arst_n_i,
        .disp_valid_i, .disp_op_i, .disp_pc_i, .disp_inst_i,
        .disp_reg1_i, .disp_reg2_i, .disp_pred_taken_i, .disp_pred_addr_i,
        .stall_i         (stall_o),
        .ex_valid_o      (ex_valid),
        .ex_op_o         (ex_op),
        .ex_pc_o         (ex_pc),
        .ex_inst_o       (ex_inst),
        .ex_reg1_o       (ex_reg1),
        .ex_reg2_o       (ex_reg2),
        .ex_pred_taken_o (ex_pred_taken),
        .ex_pred_addr_o  (ex_pred_addr)
    );

    regular_alu u_regular_alu (
        .op_i     (ex_op),
        .reg1_i   (ex_reg1),
        .reg2_i   (ex_reg2),
        .result_o (alu_res)
    );

    div_alu u_div_alu (
        .clk, .arst_n_i,
        .valid_i     (ex_valid),
        .op_i        (ex_op),
        .dividend_i  (ex_reg1),
        .divisor_i   (ex_reg2),
        .stall_o     (div_stall),
        .done_o      (div_done),
        .quotient_o  (quotient),
        .remainder_o (remainder)
    );

    branch_alu u_branch_alu (
        .valid_i        (ex_valid),
        .op_i           (ex_op),
        .pc_i           (ex_pc),
        .inst_i         (ex_inst),
        .reg1_i         (ex_reg1),
        .reg2_i         (ex_reg2),
        .pred_taken_i   (ex_pred_taken),
        .pred_addr_i    (ex_pred_addr),
        .update_valid_o (bpu_update_valid_o),
        .taken_o        (bpu_taken_o),
        .target_o       (bpu_target_o),
        .flush_o        (branch_flush_o),
        .link_o         (link)
    );

    lsu_addr_gen u_lsu_addr_gen (
        .valid_i          (ex_valid),
        .op_i             (ex_op),
        .inst_i           (ex_inst),
        .reg1_i           (ex_reg1),
        .reg2_i           (ex_reg2),
        .dcache_addr_ok_i,
        .addr_o           (lsu_addr),
        .exc_o            (lsu_exc),
        .mem_stall_o      (mem_stall),
        .dcache_valid_o, .dcache_op_o, .dcache_wdata_o, .dcache_wstrb_o
    );

    assign dcache_addr_o = lsu_addr;

    // div result is only picked up once the divider stops stalling
    ex_mem_reg u_ex_mem_reg (
        .clk, .arst_n_i,
        .ex_valid_i  (ex_valid && (div_done || !div_stall)),
        .ex_op_i     (ex_op),
        .ex_pc_i     (ex_pc),
        .alu_res_i   (alu_res),
        .quotient_i  (quotient),
        .remainder_i (remainder),
        .div_stall_i (div_stall),
        .link_i      (link),
        .mem_addr_i  (lsu_addr),
        .exc_i       (lsu_exc),
        .mem_stall_i (mem_stall),
        .stall_o, .mem_valid_o, .mem_op_o, .mem_pc_o,
        .mem_result_o, .mem_addr_o, .mem_exc_o
    );

endmodule

//--- design/lsu_addr_gen.sv
`timescale 1ns/1ps

module lsu_addr_gen (
    input  logic                        valid_i,
    input  ex_pkg::alu_op_e             op_i,
    input  logic [ex_pkg::INST_W-1:0]   inst_i,
    input  logic [ex_pkg::XLEN-1:0]     reg1_i,
    input  logic [ex_pkg::XLEN-1:0]     reg2_i,
    input  logic                        dcache_addr_ok_i,
    output logic [ex_pkg::XLEN-1:0]     addr_o,
    output mem_pkg::exc_cause_e         exc_o,
    output logic                        mem_stall_o,
    output logic                        dcache_valid_o,
    output mem_pkg::mem_op_e            dcache_op_o,
    output logic [ex_pkg::XLEN-1:0]     dcache_wdata_o,
    output logic [mem_pkg::STRB_W-1:0]  dcache_wstrb_o
);
    import ex_pkg::*;
    import mem_pkg::*;

    logic            is_mem;
    logic            is_store;
    logic            ale;
    logic [XLEN-1:0] addr;

    assign is_mem   = valid_i && (get_op_class(op_i) == CLS_MEM);
    assign is_store = op_i inside {ALU_STB, ALU_STH, ALU_STW};
    // si12 offset
    assign addr     = reg1_i + {{20{inst_i[21]}}, inst_i[21:10]};
    assign addr_o   = is_mem ? addr : '0;

    always_comb begin
        case (op_i)
            ALU_LDH, ALU_LDHU, ALU_STH: ale = addr[0];
            ALU_LDW, ALU_STW:           ale = addr[1:0] != 2'b00;
            default:                    ale = 1'b0;
        endcase
    end

    // misaligned access never reaches the cache
    assign exc_o          = (is_mem && ale) ? EXC_ALE : EXC_NONE;
    assign dcache_valid_o = is_mem && !ale;
    assign dcache_op_o    = is_store ? MEM_WRITE : MEM_READ;
    assign mem_stall_o    = dcache_valid_o && !dcache_addr_ok_i;

    always_comb begin
        dcache_wdata_o = '0;
        dcache_wstrb_o = '1;
        case (op_i)
            ALU_STB: begin
                dcache_wdata_o = {4{reg2_i[7:0]}};
                dcache_wstrb_o = {{(STRB_W-1){1'b0}}, 1'b1} << addr[1:0];
            end
            ALU_STH: begin
                dcache_wdata_o = {2{reg2_i[15:0]}};
                dcache_wstrb_o = addr[1] ? 4'b1100 : 4'b0011;
            end
            ALU_STW: begin
                dcache_wdata_o = reg2_i;
            end
            default: begin
            end
        endcase
    end

    always_comb begin
        if (dcache_valid_o) begin
            assert (dcache_wstrb_o != '0)
                else $error("cache request with empty byte strobe");
        end
    end

endmodule

//--- design/mem_pkg.sv
package mem_pkg;

    localparam int STRB_W = 4;

    // ecode field of the core's exception encoding
    typedef enum logic [6:0] {
        EXC_NONE = 7'h00,
        EXC_ALE  = 7'h09
    } exc_cause_e;

    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_e;

endpackage

//--- design/regular_alu.sv
`timescale 1ns/1ps

module regular_alu (
    input  ex_pkg::alu_op_e             op_i,
    input  logic [ex_pkg::XLEN-1:0]     reg1_i,
    input  logic [ex_pkg::XLEN-1:0]     reg2_i,
    output logic [ex_pkg::XLEN-1:0]     result_o
);
    import ex_pkg::*;

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    // only the low five bits count for shifts
    assign shamt       = reg2_i[4:0];
    assign lt_signed   = $signed(reg1_i) < $signed(reg2_i);
    assign lt_unsigned = reg1_i < reg2_i;

    always_comb begin
        case (op_i)
            ALU_ADD:  result_o = reg1_i + reg2_i;
            ALU_SUB:  result_o = reg1_i - reg2_i;
            ALU_SLT:  result_o = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
            ALU_AND:  result_o = reg1_i & reg2_i;
            ALU_OR:   result_o = reg1_i | reg2_i;
            ALU_XOR:  result_o = reg1_i ^ reg2_i;
            ALU_NOR:  result_o = ~(reg1_i | reg2_i);
            ALU_SLL:  result_o = reg1_i << shamt;
            ALU_SRL:  result_o = reg1_i >> shamt;
            ALU_SRA:  result_o = $unsigned($signed(reg1_i) >>> shamt);
            default:  result_o = '0;
        endcase
    end

endmodule

//--- project.f
design/ex_pkg.sv
design/mem_pkg.sv
design/ex_dispatch_reg.sv
design/regular_alu.sv
design/div_alu.sv
design/branch_alu.sv
design/lsu_addr_gen.sv
design/ex_mem_reg.sv
design/ex_stage_top.sv
sim/tb_ex_stage.sv

//--- run.sh
#!/bin/sh
# build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f project.f --top-module tb_ex_stage -o sim_ex_stage &&
    ./obj_dir/sim_ex_stage | tee /dev/stderr | grep -q "NO ERRORS" &&
    echo "simulation passed" ||
    { echo "simulation failed"; exit 1; }

//--- sim/ex_stimulus.txt
# op(dec) pc inst reg1 reg2 pred_taken pred_addr | expected: result addr strb exc flush
# branch: addr = redirect target, strb = taken; load/store: result = cache write data
1  00001000 00000000 7fffffff 00000001 0 00000000 80000000 0 0 00 0
2  00001004 00000000 00000005 00000007 0 00000000 fffffffe 0 0 00 0
3  00001008 00000000 ffffffff 00000001 0 00000000 00000001 0 0 00 0
4  0000100c 00000000 ffffffff 00000001 0 00000000 00000000 0 0 00 0
5  00001010 00000000 f0f0f0f0 ff00ff00 0 00000000 f000f000 0 0 00 0
6  00001014 00000000 f0f0f0f0 0f0f0000 0 00000000 fffff0f0 0 0 00 0
7  00001018 00000000 aaaaaaaa ffffffff 0 00000000 55555555 0 0 00 0
8  0000101c 00000000 0f0f0000 000000f0 0 00000000 f0f0ff0f 0 0 00 0
9  00001020 00000000 00000001 00000024 0 00000000 00000010 0 0 00 0
10 00001024 00000000 80000000 0000003f 0 00000000 00000001 0 0 00 0
11 00001028 00000000 80000000 00000021 0 00000000 c0000000 0 0 00 0
12 0000102c 00000000 fffffff9 00000002 0 00000000 fffffffd 0 0 00 0
13 00001030 00000000 fffffff9 00000002 0 00000000 ffffffff 0 0 00 0
12 00001034 00000000 00000064 fffffff9 0 00000000 fffffff2 0 0 00 0
13 00001038 00000000 00000064 fffffff9 0 00000000 00000002 0 0 00 0
14 0000103c 00000000 ffffffff 00000002 0 00000000 7fffffff 0 0 00 0
15 00001040 00000000 00000064 00000007 0 00000000 00000002 0 0 00 0
14 00001044 00000000 00000007 00000000 0 00000000 ffffffff 0 0 00 0
13 00001048 00000000 fffffff9 00000000 0 00000000 fffffff9 0 0 00 0
16 00001000 00001000 00000005 00000005 1 00001010 00000000 00001010 1 00 0
17 00001100 00001000 00000005 00000005 1 00001110 00000000 00001104 0 00 1
18 00001200 03ffe000 fffffffe 00000001 0 00000000 00000000 000011e0 1 00 1
21 00001300 00001000 fffffffe 00000001 1 00001314 00000000 00001310 1 00 1
20 00001400 00001000 fffffffe 00000001 0 00000000 00000000 00001404 0 00 0
19 00001500 00001000 00000001 fffffffe 1 00001510 00000000 00001510 1 00 0
22 00001600 00001000 00002000 00000000 1 00002010 00001604 00002010 1 00 0
24 00001700 00040000 00000000 00000000 0 00000000 00001704 00001b00 1 00 1
23 00001800 03ffffff 00000000 00000000 1 000017fc 00000000 000017fc 1 00 0
30 00002000 00000c00 00008000 000000a5 0 00000000 a5a5a5a5 00008003 8 00 0
31 00002004 00000800 00008000 1234beef 0 00000000 beefbeef 00008002 c 00 0
32 00002008 003ff000 00008010 deadbeef 0 00000000 deadbeef 0000800c f 00 0
29 0000200c 00002000 00008000 00000000 0 00000000 00000000 00008008 f 00 0
25 00002010 00000000 00008001 00000000 0 00000000 00000000 00008001 f 00 0
28 00002014 00000000 00008006 00000000 0 00000000 00000000 00008006 f 00 0
27 00002018 00000000 00008001 00000000 0 00000000 00000000 00008001 0 09 0
32 0000201c 00000000 00008002 11111111 0 00000000 00000000 00008002 0 09 0
29 00002020 00001400 00008000 00000000 0 00000000 00000000 00008005 0 09 0
31 00002024 00000000 00008003 22222222 0 00000000 00000000 00008003 0 09 0
1  00002028 00000000 00000001 00000002 0 00000000 00000003 0 0 00 0

//--- sim/tb_ex_stage.sv
`timescale 1ns/1ps

module tb_ex_stage;
    import ex_pkg::*;
    import mem_pkg::*;

    localparam int MAX_N = 64;
    localparam int TIMEOUT = 200;

    logic clk;
    logic arst_n_i;
    logic disp_valid_i;
    alu_op_e disp_op_i;
    logic [31:0] disp_pc_i, disp_inst_i, disp_reg1_i, disp_reg2_i, disp_pred_addr_i;
    logic disp_pred_taken_i;
    logic dcache_addr_ok_i;
    logic dcache_valid_o;
    mem_op_e dcache_op_o;
    logic [31:0] dcache_addr_o, dcache_wdata_o;
    logic [3:0] dcache_wstrb_o;
    logic branch_flush_o, bpu_update_valid_o, bpu_taken_o;
    logic [31:0] bpu_target_o;
    logic stall_o, mem_valid_o;
    alu_op_e mem_op_o;
    logic [31:0] mem_pc_o, mem_result_o, mem_addr_o;
    exc_cause_e mem_exc_o;

    int op_t[MAX_N];
    logic [31:0] pc_t[MAX_N], inst_t[MAX_N], r1_t[MAX_N], r2_t[MAX_N];
    logic [31:0] pt_t[MAX_N], pa_t[MAX_N];
    logic [31:0] e_res[MAX_N], e_addr[MAX_N], e_strb[MAX_N], e_exc[MAX_N], e_flush[MAX_N];
    int n;
    int errors;
    int checks;
    int done_cnt;
    int disp_idx;
    int ex_q[$];
    int mem_q[$];
    logic prev_stall;
    logic timed_out;
    logic [31:0] lfsr_state;
    logic pending;
    logic [1:0] ok_delay;
    int wait_cnt;

    ex_stage_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // taps 32, 22, 2, 1
    function automatic logic step_lfsr();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    task automatic check_val(string what, logic [31:0] got, logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // cache address acceptance after 0..3 cycles
    initial begin
        dcache_addr_ok_i = 1'b0;
        lfsr_state = 32'h6b33_cf33;
        pending = 1'b0;
        wait_cnt = 0;
        ok_delay = 2'd0;
        forever begin
            @(posedge clk);
            #0.5;
            if (dcache_addr_ok_i) begin
                dcache_addr_ok_i = 1'b0;
                pending = 1'b0;
            end else if (dcache_valid_o) begin
                if (!pending) begin
                    pending = 1'b1;
                    ok_delay[1] = step_lfsr();
                    ok_delay[0] = step_lfsr();
                    wait_cnt = 0;
                end
                if (wait_cnt >= int'(ok_delay)) dcache_addr_ok_i = 1'b1;
                else wait_cnt++;
            end
        end
    end

    // outputs are sampled mid-cycle, away from the edges
    always @(negedge clk) begin
        int idx;
        if (arst_n_i) begin
            if (mem_valid_o) begin
                if (prev_stall) begin
                    errors++;
                    $display("mem_valid_o rose at %0t after a stalled edge", $time);
                end
                if (mem_q.size() == 0) begin
                    errors++;
                    $display("mem_valid_o at %0t with no instruction outstanding", $time);
                end else begin
                    idx = mem_q.pop_front();
                    done_cnt++;
                    check_val("mem_pc_o", mem_pc_o, pc_t[idx]);
                    check_val("mem_op_o", 32'(mem_op_o), 32'(op_t[idx]));
                    check_val("mem_exc_o", 32'(mem_exc_o), e_exc[idx]);
                    if (op_t[idx] >= 25) check_val("mem_addr_o", mem_addr_o, e_addr[idx]);
                    else check_val("mem_result_o", mem_result_o, e_res[idx]);
                end
            end
            if (ex_q.size() != 0) begin
                idx = ex_q[0];
                if (op_t[idx] >= 16 && op_t[idx] <= 24) begin
                    check_val("bpu_update_valid_o", 32'(bpu_update_valid_o), 32'd1);
                    check_val("branch_flush_o", 32'(branch_flush_o), e_flush[idx]);
                    check_val("bpu_taken_o", 32'(bpu_taken_o), e_strb[idx]);
                    check_val("bpu_target_o", bpu_target_o, e_addr[idx]);
                end else begin
                    check_val("bpu_update_valid_o", 32'(bpu_update_valid_o), 32'd0);
                end
                if (op_t[idx] >= 25 && e_exc[idx] == 32'd0) begin
                    check_val("dcache_valid_o", 32'(dcache_valid_o), 32'd1);
                    // st.b, st.h and st.w write
                    check_val("dcache_op_o", 32'(dcache_op_o),
                        32'((op_t[idx] >= 30) ? MEM_WRITE : MEM_READ));
                    check_val("dcache_addr_o", dcache_addr_o, e_addr[idx]);
                    check_val("dcache_wstrb_o", 32'(dcache_wstrb_o), e_strb[idx]);
                    check_val("dcache_wdata_o", dcache_wdata_o, e_res[idx]);
                end else begin
                    check_val("dcache_valid_o", 32'(dcache_valid_o), 32'd0);
                end
                if (!stall_o) begin
                    void'(ex_q.pop_front());
                    mem_q.push_back(idx);
                end
            end
            if (disp_valid_i && !stall_o) ex_q.push_back(disp_idx);
            prev_stall = stall_o;
        end
    end

    initial begin
        int fd;
        int code;
        int waited;
        int op;
        logic [31:0] f[11];
        logic accepted;
        string line;
        arst_n_i = 1'b0;
        disp_valid_i = 1'b0;
        disp_op_i = ALU_NOP;
        disp_pc_i = '0;
        disp_inst_i = '0;
        disp_reg1_i = '0;
        disp_reg2_i = '0;
        disp_pred_taken_i = 1'b0;
        disp_pred_addr_i = '0;
        n = 0;
        errors = 0;
        checks = 0;
        done_cnt = 0;
        disp_idx = 0;
        prev_stall = 1'b0;
        timed_out = 1'b0;
        fd = $fopen("sim/ex_stimulus.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("cannot open sim/ex_stimulus.txt");
        end else begin
            while (!$feof(fd) && n < MAX_N) begin
                line = "";
                code = $fgets(line, fd);
                if (line.len() > 1 && line.getc(0) != "#") begin
                    code = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h", op,
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
                    if (code == 12) begin
                        op_t[n] = op;
                        pc_t[n] = f[0];
                        inst_t[n] = f[1];
                        r1_t[n] = f[2];
                        r2_t[n] = f[3];
                        pt_t[n] = f[4];
                        pa_t[n] = f[5];
                        e_res[n] = f[6];
                        e_addr[n] = f[7];
                        e_strb[n] = f[8];
                        e_exc[n] = f[9];
                        e_flush[n] = f[10];
                        n++;
                    end
                end
            end
            $fclose(fd);
        end
        repeat (8) @(posedge clk);
        #0.5;
        arst_n_i = 1'b1;
        for (int i = 0; i < n && !timed_out; i++) begin
            @(posedge clk);
            #0.5;
            disp_idx = i;
            disp_valid_i = 1'b1;
            disp_op_i = alu_op_e'(6'(op_t[i]));
            disp_pc_i = pc_t[i];
            disp_inst_i = inst_t[i];
            disp_reg1_i = r1_t[i];
            disp_reg2_i = r2_t[i];
            disp_pred_taken_i = pt_t[i][0];
            disp_pred_addr_i = pa_t[i];
            // held until an edge without stall takes it
            accepted = 1'b0;
            waited = 0;
            while (!accepted && !timed_out) begin
                @(negedge clk);
                if (!stall_o) accepted = 1'b1;
                else if (++waited > TIMEOUT) timed_out = 1'b1;
            end
        end
        @(posedge clk);
        #0.5;
        disp_valid_i = 1'b0;
        waited = 0;
        while (done_cnt < n && !timed_out) begin
            @(negedge clk);
            if (++waited > TIMEOUT) timed_out = 1'b1;
        end
        repeat (4) @(negedge clk);
        $display("checks %0d, errors %0d, retired %0d of %0d", checks, errors, done_cnt, n);
        if (timed_out) begin
            $display("timed out waiting for the DUT to accept or retire an instruction");
            $display("ERRORS FOUND");
        end else if (errors == 0 && done_cnt == n && n > 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
